//--- hdl/mdc_pkg.sv
package mdc_pkg;

    // ==============================
    // widths
    // ==============================
    localparam int ELEM_W      = 11;
    localparam int DATA_CODE_W = 15;
    localparam int MODE_W      = 5;
    localparam int MODE_CODE_W = 9;
    localparam int PARITY_W    = 4;
    localparam int MINOR_W     = 23;
    localparam int DET_W       = 51;
    localparam int OUT_W       = 207;
    localparam int SLOT_W      = 4;

    // ==============================
    // frame shape and modes
    // ==============================
    localparam int MAT_N    = 4;
    localparam int N_ELEMS  = 16;
    localparam int N_MINORS = 9;
    localparam int N_DETS   = 4;

    localparam logic [MODE_W-1:0] MODE_2X2 = 5'b00100;
    localparam logic [MODE_W-1:0] MODE_3X3 = 5'b00110;

    // 3x3 layout, pad bits on top
    typedef struct packed {
        logic [2:0]                        pad;
        logic [0:N_DETS-1][DET_W-1:0]      det;
    } dets_view_t;

    // slot 0 sits in the most significant field in both views
    typedef union packed {
        logic [0:N_MINORS-1][MINOR_W-1:0]  minors;
        dets_view_t                        dets;
    } result_word_u;

endpackage

// one window of three rows by three columns
interface window_if
    import mdc_pkg::*;
();
    logic                     valid;
    logic [MODE_W-1:0]        mode;
    logic [SLOT_W-1:0]        slot;
    logic                     last;
    logic signed [ELEM_W-1:0] top0;
    logic signed [ELEM_W-1:0] top1;
    logic signed [ELEM_W-1:0] top2;
    logic signed [ELEM_W-1:0] mid0;
    logic signed [ELEM_W-1:0] mid1;
    logic signed [ELEM_W-1:0] mid2;
    logic signed [ELEM_W-1:0] bot0;
    logic signed [ELEM_W-1:0] bot1;
    logic signed [ELEM_W-1:0] bot2;

    modport seq (
        output valid, mode, slot, last,
        output top0, top1, top2, mid0, mid1, mid2, bot0, bot1, bot2
    );

    modport eng (
        input valid, mode, slot, last,
        input top0, top1, top2, mid0, mid1, mid2, bot0, bot1, bot2
    );
endinterface

//--- hdl/hamming_decoder.sv
module hamming_decoder
    import mdc_pkg::*;
#(
    parameter int DATA_W = 11
) (
    input  logic [DATA_W+PARITY_W-1:0] code,
    output logic [DATA_W-1:0]          data
);

    logic [3:0]                 syndrome;
    logic [DATA_W+PARITY_W-1:0] fixed;

    // position p lives at bit (width - p), msb is position 1
    always_comb begin
        syndrome = '0;
        for (int p = 1; p <= DATA_W + PARITY_W; p++) begin
            if (code[DATA_W+PARITY_W-p]) begin
                syndrome = syndrome ^ 4'(p);
            end
        end
    end

    // single error correction
    always_comb begin
        fixed = code;
        if (syndrome != '0 && int'(syndrome) <= DATA_W + PARITY_W) begin
            fixed[DATA_W+PARITY_W-int'(syndrome)] = ~code[DATA_W+PARITY_W-int'(syndrome)];
        end
    end

    // skip parity positions 1, 2, 4, 8
    always_comb begin
        int k;
        k = DATA_W - 1;
        data = '0;
        for (int p = 3; p <= DATA_W + PARITY_W; p++) begin
            if (p != 4 && p != 8) begin
                data[k] = fixed[DATA_W+PARITY_W-p];
                k = k - 1;
            end
        end
    end

endmodule

//--- hdl/matrix_buffer.sv
module matrix_buffer
    import mdc_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  logic [ELEM_W-1:0]        elem,
    input  logic [MODE_W-1:0]        mode,
    output logic signed [ELEM_W-1:0] elements [N_ELEMS],
    output logic [MODE_W-1:0]        frame_mode,
    output logic                     frame_full
);

    logic [$clog2(N_ELEMS)-1:0] cnt;
    logic                       last_elem;

    assign last_elem = in_valid && (cnt == ($clog2(N_ELEMS))'(N_ELEMS - 1));

    // ==============================
    // capture
    // ==============================
    // row-major, index = row * 4 + col
    always_ff @(posedge clk) begin
        if (in_valid) begin
            elements[cnt] <= elem;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt        <= '0;
            frame_mode <= '0;
            frame_full <= 1'b0;
        end else begin
            frame_full <= last_elem;
            if (in_valid) begin
                // wraps back to zero after the sixteenth element
                cnt <= cnt + 1'b1;
                if (cnt == '0) begin
                    frame_mode <= mode;
                end
            end
        end
    end

    // ==============================
    // checks
    // ==============================
    a_known_mode : assert property (
        @(posedge clk) disable iff (!rst_n)
        frame_full |-> (frame_mode == MODE_2X2 || frame_mode == MODE_3X3)
    ) else $error("frame captured with unknown mode %b", frame_mode);

    // a frame is sixteen back-to-back valid cycles
    a_no_gap : assert property (
        @(posedge clk) disable iff (!rst_n)
        (cnt != '0) |-> in_valid
    ) else $error("in_valid dropped after %0d elements", cnt);

endmodule

//--- hdl/window_sequencer.sv
module window_sequencer
    import mdc_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     frame_full,
    input  logic [MODE_W-1:0]        frame_mode,
    input  logic signed [ELEM_W-1:0] elements [N_ELEMS],
    window_if.seq                    win
);

    logic              busy;
    logic [SLOT_W-1:0] slot_q;
    logic [SLOT_W-1:0] cur_slot;
    logic [SLOT_W-1:0] last_slot;
    logic              is_3x3;
    logic              step;
    logic [SLOT_W-1:0] row_base;
    logic [SLOT_W-1:0] col_base;
    logic [SLOT_W-1:0] mid_row;

    // zero outside the matrix
    function automatic logic signed [ELEM_W-1:0] elem_at(
        input logic [SLOT_W-1:0] row,
        input logic [SLOT_W-1:0] col
    );
        if (row >= MAT_N || col >= MAT_N) begin
            return '0;
        end
        return elements[row*MAT_N+col];
    endfunction

    assign is_3x3    = (frame_mode == MODE_3X3);
    assign last_slot = is_3x3 ? SLOT_W'(N_DETS - 1) : SLOT_W'(N_MINORS - 1);

    // window 0 goes out in the frame_full cycle itself
    assign step     = frame_full | busy;
    assign cur_slot = busy ? slot_q : '0;

    // ==============================
    // window position
    // ==============================
    always_comb begin
        if (is_3x3) begin
            row_base = SLOT_W'(cur_slot[1]);
            col_base = SLOT_W'(cur_slot[0]);
            mid_row  = row_base + SLOT_W'(1);
        end else begin
            row_base = cur_slot / SLOT_W'(3);
            col_base = cur_slot % SLOT_W'(3);
            mid_row  = row_base;
        end
    end

    assign win.valid = step;
    assign win.mode  = frame_mode;
    assign win.slot  = cur_slot;
    assign win.last  = step && (cur_slot == last_slot);

    // top row only feeds the 3x3 cofactor sum
    assign win.top0 = is_3x3 ? elem_at(row_base, col_base) : '0;
    assign win.top1 = is_3x3 ? elem_at(row_base, col_base + SLOT_W'(1)) : '0;
    assign win.top2 = is_3x3 ? elem_at(row_base, col_base + SLOT_W'(2)) : '0;
    assign win.mid0 = elem_at(mid_row, col_base);
    assign win.mid1 = elem_at(mid_row, col_base + SLOT_W'(1));
    assign win.mid2 = elem_at(mid_row, col_base + SLOT_W'(2));
    assign win.bot0 = elem_at(mid_row + SLOT_W'(1), col_base);
    assign win.bot1 = elem_at(mid_row + SLOT_W'(1), col_base + SLOT_W'(1));
    assign win.bot2 = elem_at(mid_row + SLOT_W'(1), col_base + SLOT_W'(2));

    // slot counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            slot_q <= '0;
        end else if (step) begin
            if (cur_slot == last_slot) begin
                busy   <= 1'b0;
                slot_q <= '0;
            end else begin
                busy   <= 1'b1;
                slot_q <= cur_slot + SLOT_W'(1);
            end
        end
    end

    a_no_overlap : assert property (
        @(posedge clk) disable iff (!rst_n)
        frame_full |-> !busy
    ) else $error("new frame while windows still issuing, slot %0d", slot_q);

endmodule

//--- hdl/det_engine.sv
module det_engine
    import mdc_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    window_if.eng                    win,
    output logic                     res_valid,
    output logic [SLOT_W-1:0]        res_slot,
    output logic                     res_last,
    output logic [MODE_W-1:0]        res_mode,
    output logic signed [DET_W-1:0]  res_value
);

    // stage 1 state
    logic                      s1_valid;
    logic [SLOT_W-1:0]         s1_slot;
    logic                      s1_last;
    logic [MODE_W-1:0]         s1_mode;
    logic signed [ELEM_W-1:0]  s1_top0;
    logic signed [ELEM_W-1:0]  s1_top1;
    logic signed [ELEM_W-1:0]  s1_top2;
    logic signed [MINOR_W-1:0] s1_m01;
    logic signed [MINOR_W-1:0] s1_m12;
    logic signed [MINOR_W-1:0] s1_m02;

    logic signed [MINOR_W-1:0] m01;
    logic signed [MINOR_W-1:0] m12;
    logic signed [MINOR_W-1:0] m02;
    logic signed [DET_W-1:0]   cofactor_sum;

    // ==============================
    // stage 1, minors of mid/bot rows
    // ==============================
    assign m01 = win.mid0 * win.bot1 - win.mid1 * win.bot0;
    assign m12 = win.mid1 * win.bot2 - win.mid2 * win.bot1;
    assign m02 = win.mid0 * win.bot2 - win.mid2 * win.bot0;

    always_ff @(posedge clk) begin
        if (win.valid) begin
            s1_slot <= win.slot;
            s1_last <= win.last;
            s1_mode <= win.mode;
            s1_top0 <= win.top0;
            s1_top1 <= win.top1;
            s1_top2 <= win.top2;
            s1_m01  <= m01;
            s1_m12  <= m12;
            s1_m02  <= m02;
        end
    end

    // ==============================
    // stage 2, expansion along top row
    // ==============================
    // worst case needs 36 bits, the 51-bit field holds it with room
    assign cofactor_sum = s1_top0 * s1_m12 - s1_top1 * s1_m02 + s1_top2 * s1_m01;

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            res_slot <= s1_slot;
            res_last <= s1_last;
            res_mode <= s1_mode;
            if (s1_mode == MODE_3X3) begin
                res_value <= cofactor_sum;
            end else begin
                res_value <= DET_W'(s1_m01);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            s1_valid  <= win.valid;
            res_valid <= s1_valid;
        end
    end

endmodule

//--- hdl/result_assembler.sv
module result_assembler
    import mdc_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     res_valid,
    input  logic [SLOT_W-1:0]        res_slot,
    input  logic                     res_last,
    input  logic [MODE_W-1:0]        res_mode,
    input  logic signed [DET_W-1:0]  res_value,
    output logic                     out_valid,
    output logic [OUT_W-1:0]         out_data
);

    result_word_u word_q;

    // ==============================
    // slot write
    // ==============================
    always_ff @(posedge clk) begin
        if (res_valid) begin
            if (res_mode == MODE_3X3) begin
                word_q.dets.det[res_slot] <= res_value;
                // left over from an earlier 2x2 frame otherwise
                word_q.dets.pad <= '0;
            end else begin
                word_q.minors[res_slot] <= res_value[MINOR_W-1:0];
            end
        end
    end

    // one pulse per frame, after the last slot lands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= res_valid && res_last;
        end
    end

    assign out_data = out_valid ? OUT_W'(word_q) : '0;

    a_slot_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        res_valid |-> (res_slot < ((res_mode == MODE_3X3) ? N_DETS : N_MINORS))
    ) else $error("result slot %0d out of range for mode %b", res_slot, res_mode);

endmodule

//--- hdl/mdc_top.sv
module mdc_top
    import mdc_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic [DATA_CODE_W-1:0] in_data,
    input  logic [MODE_CODE_W-1:0] in_mode,
    output logic                   out_valid,
    output logic [OUT_W-1:0]       out_data
);

    logic [MODE_W-1:0]        mode_dec;
    logic [ELEM_W-1:0]        elem_dec;
    logic signed [ELEM_W-1:0] elements [N_ELEMS];
    logic [MODE_W-1:0]        frame_mode;
    logic                     frame_full;

    logic                     res_valid;
    logic [SLOT_W-1:0]        res_slot;
    logic                     res_last;
    logic [MODE_W-1:0]        res_mode;
    logic signed [DET_W-1:0]  res_value;

    window_if win ();

    // ==============================
    // input decode
    // ==============================
    hamming_decoder #(.DATA_W(MODE_W)) u_mode_dec (
        .code (in_mode),
        .data (mode_dec)
    );

    hamming_decoder #(.DATA_W(ELEM_W)) u_data_dec (
        .code (in_data),
        .data (elem_dec)
    );

    // ==============================
    // datapath
    // ==============================
    matrix_buffer u_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .elem       (elem_dec),
        .mode       (mode_dec),
        .elements   (elements),
        .frame_mode (frame_mode),
        .frame_full (frame_full)
    );

    window_sequencer u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .frame_full (frame_full),
        .frame_mode (frame_mode),
        .elements   (elements),
        .win        (win.seq)
    );

    det_engine u_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .win       (win.eng),
        .res_valid (res_valid),
        .res_slot  (res_slot),
        .res_last  (res_last),
        .res_mode  (res_mode),
        .res_value (res_value)
    );

    result_assembler u_assembler (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_valid (res_valid),
        .res_slot  (res_slot),
        .res_last  (res_last),
        .res_mode  (res_mode),
        .res_value (res_value),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

//--- verification/mdc_tb.sv
module mdc_tb
    import mdc_pkg::*;
();

    localparam int          CLK_PERIOD   = 100;
    localparam int          RESET_CYCLES = 10;
    localparam int          FRAME_CYCLES = 40;
    localparam int          N_FRAMES     = 28;
    localparam logic [31:0] SEED         = 32'h6e37_23a8;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   in_valid;
    logic [DATA_CODE_W-1:0] in_data;
    logic [MODE_CODE_W-1:0] in_mode;
    logic                   out_valid;
    logic [OUT_W-1:0]       out_data;

    logic [31:0]              lfsr_q;
    logic signed [ELEM_W-1:0] cur_elems [N_ELEMS];
    result_word_u             exp_q [$];
    logic [MODE_W-1:0]        mode_q [$];
    int                       sent = 0;
    int                       done_count = 0;
    logic                     was_valid = 1'b0;
    result_word_u             got_word;
    result_word_u             exp_word;
    logic [MODE_W-1:0]        exp_mode;

    mdc_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_mode   (in_mode),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==============================
    // helpers
    // ==============================
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_advance(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_advance(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    // position p sits at bit (n - p) of the result
    function automatic logic [14:0] hamming_encode(input logic [10:0] data, input int data_w);
        logic [15:1] pos;
        logic [14:0] code;
        logic        par;
        int          n;
        int          k;
        n = data_w + 4;
        pos = '0;
        code = '0;
        k = data_w - 1;
        for (int p = 3; p <= n; p++) begin
            if (p != 4 && p != 8) begin
                pos[p] = data[k];
                k = k - 1;
            end
        end
        for (int i = 0; i < 4; i++) begin
            par = 1'b0;
            for (int p = 1; p <= n; p++) begin
                if (((p >> i) & 1) == 1 && p != (1 << i)) begin
                    par = par ^ pos[p];
                end
            end
            pos[1 << i] = par;
        end
        for (int p = 1; p <= n; p++) begin
            code[n-p] = pos[p];
        end
        return code;
    endfunction

    // determinants straight from the matrix using the rule of Sarrus for 3x3
    function automatic result_word_u expected_word(
        input logic signed [ELEM_W-1:0] m [N_ELEMS],
        input logic [MODE_W-1:0]        mode
    );
        result_word_u w;
        longint       x [3][3];
        longint       d;
        int           r;
        int           c;
        w = '0;
        if (mode == MODE_3X3) begin
            for (int k = 0; k < N_DETS; k++) begin
                r = k / 2;
                c = k % 2;
                for (int i = 0; i < 3; i++) begin
                    for (int j = 0; j < 3; j++) begin
                        x[i][j] = longint'(m[(r+i)*MAT_N+c+j]);
                    end
                end
                d = x[0][0] * x[1][1] * x[2][2] + x[0][1] * x[1][2] * x[2][0]
                  + x[0][2] * x[1][0] * x[2][1] - x[0][2] * x[1][1] * x[2][0]
                  - x[0][1] * x[1][0] * x[2][2] - x[0][0] * x[1][2] * x[2][1];
                w.dets.det[k] = DET_W'(d);
            end
        end else begin
            for (int k = 0; k < N_MINORS; k++) begin
                r = k / 3;
                c = k % 3;
                d = longint'(m[r*MAT_N+c]) * longint'(m[(r+1)*MAT_N+c+1])
                  - longint'(m[r*MAT_N+c+1]) * longint'(m[(r+1)*MAT_N+c]);
                w.minors[k] = MINOR_W'(d);
            end
        end
        return w;
    endfunction

    // ==============================
    // compare tasks
    // ==============================
    task automatic check_minors(input result_word_u got, input result_word_u exp);
        for (int k = 0; k < N_MINORS; k++) begin
            if (got.minors[k] !== exp.minors[k]) begin
                abort_run($sformatf("ERR @%0t: minor %0d is %0d, expected %0d", $time, k,
                    $signed(got.minors[k]), $signed(exp.minors[k])));
            end
        end
    endtask

    task automatic check_dets(input result_word_u got, input result_word_u exp);
        if (got.dets.pad !== 3'b000) begin
            abort_run($sformatf("ERR @%0t: pad bits are %b", $time, got.dets.pad));
        end
        for (int k = 0; k < N_DETS; k++) begin
            if (got.dets.det[k] !== exp.dets.det[k]) begin
                abort_run($sformatf("ERR @%0t: det %0d is %0d, expected %0d", $time, k,
                    $signed(got.dets.det[k]), $signed(exp.dets.det[k])));
            end
        end
    endtask

    task automatic check_idle(input logic [OUT_W-1:0] data);
        if (data !== '0) begin
            abort_run($sformatf("ERR @%0t: out_data nonzero while out_valid low", $time));
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (out_valid) begin
                if (was_valid) begin
                    abort_run("out_valid stayed high for more than one cycle");
                end else if (exp_q.size() == 0) begin
                    abort_run("out_valid pulsed with no frame outstanding");
                end else begin
                    got_word = out_data;
                    exp_word = exp_q.pop_front();
                    exp_mode = mode_q.pop_front();
                    if (exp_mode == MODE_3X3) begin
                        check_dets(got_word, exp_word);
                    end else begin
                        check_minors(got_word, exp_word);
                    end
                    done_count++;
                end
            end else begin
                check_idle(out_data);
            end
            was_valid = out_valid;
        end
    end

    // ==============================
    // stimulus
    // ==============================
    task automatic fill_random();
        logic [31:0] v;
        for (int i = 0; i < N_ELEMS; i++) begin
            take_bits(ELEM_W, v);
            cur_elems[i] = v[ELEM_W-1:0];
        end
    endtask

    task automatic fill_extreme();
        logic [31:0] v;
        for (int i = 0; i < N_ELEMS; i++) begin
            take_bits(1, v);
            cur_elems[i] = v[0] ? 11'sh400 : 11'sh3ff;
        end
    endtask

    task automatic run_frame(input logic [MODE_W-1:0] mode, input bit flip_data,
                             input bit flip_mode);
        logic [14:0] mcode;
        logic [14:0] dcode;
        logic [31:0] v;
        mcode = hamming_encode(11'(mode), MODE_W);
        if (flip_mode) begin
            take_bits(4, v);
            mcode[MODE_CODE_W-1-(v % MODE_CODE_W)] = ~mcode[MODE_CODE_W-1-(v % MODE_CODE_W)];
        end
        exp_q.push_back(expected_word(cur_elems, mode));
        mode_q.push_back(mode);
        sent++;
        for (int i = 0; i < N_ELEMS; i++) begin
            dcode = hamming_encode(cur_elems[i], ELEM_W);
            if (flip_data) begin
                take_bits(4, v);
                dcode[DATA_CODE_W-1-(v % DATA_CODE_W)] = ~dcode[DATA_CODE_W-1-(v % DATA_CODE_W)];
            end
            @(posedge clk);
            in_valid <= 1'b1;
            in_data  <= dcode;
            in_mode  <= mcode[MODE_CODE_W-1:0];
        end
        @(posedge clk);
        in_valid <= 1'b0;
        in_data  <= '0;
        in_mode  <= '0;
        while (done_count < sent) begin
            @(posedge clk);
        end
    endtask

    // watchdog
    initial begin
        #((RESET_CYCLES + FRAME_CYCLES * N_FRAMES) * CLK_PERIOD);
        abort_run("timed out waiting for out_valid");
    end

    initial begin
        logic [31:0] v;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        in_mode  = '0;
        lfsr_q   = SEED;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // same frame clean and then with one flipped bit per element
        fill_random();
        run_frame(MODE_2X2, 1'b0, 1'b0);
        run_frame(MODE_2X2, 1'b1, 1'b0);
        fill_random();
        run_frame(MODE_3X3, 1'b0, 1'b0);
        run_frame(MODE_3X3, 1'b1, 1'b0);

        // corner values only
        fill_extreme();
        run_frame(MODE_3X3, 1'b0, 1'b0);
        fill_extreme();
        run_frame(MODE_2X2, 1'b1, 1'b0);

        // damaged mode codeword
        fill_random();
        run_frame(MODE_2X2, 1'b0, 1'b1);
        fill_random();
        run_frame(MODE_3X3, 1'b1, 1'b1);

        take_bits(1, v);
        for (int i = 0; i < 20; i++) begin
            fill_random();
            run_frame(((i + int'(v[0])) % 2 == 1) ? MODE_3X3 : MODE_2X2, i % 2 == 1, i % 3 == 0);
        end

        // a stray pulse after the last frame still reaches the monitor
        repeat (4) @(posedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- sim.f
hdl/mdc_pkg.sv
hdl/hamming_decoder.sv
hdl/matrix_buffer.sv
hdl/window_sequencer.sv
hdl/det_engine.sv
hdl/result_assembler.sv
hdl/mdc_top.sv
verification/mdc_tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench, pass only if the log holds the pass line
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module mdc_tb -o mdc_sim \
    > build.log 2>&1 \
    && ./obj_dir/mdc_sim > sim.log 2>&1 \
    && grep -q "^NO ERRORS$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
